/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/100ps
TOP      := mem_stage_tb
FILELIST := sources.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: compile run clean

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(BIN) | tee /dev/stderr | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* dv/mem_stage_checker.sv */
module mem_stage_checker (
   input logic        clk,
   input logic [31:0] reg_wdata,
   input logic        reg_we,
   input logic [4:0]  reg_rd,
   input logic [31:0] uart_dout,
   input logic        uart_we
);

   timeunit 1ns;
   timeprecision 100ps;

   string       op_q[$];
   string       desc_q[$];
   logic [31:0] exp_q[$];
   logic [4:0]  rd_q[$];

   bit          in_flight = 1'b0;
   string       cur_op;
   string       cur_desc;
   logic [31:0] cur_exp;
   logic [4:0]  cur_rd;
   int          item_errors = 0;
   int          pass_count  = 0;
   int          fail_count  = 0;

   task automatic expect_item(input string op, input string desc, input logic [31:0] exp_val,
                              input logic [4:0] rd);
      op_q.push_back(op);
      desc_q.push_back(desc);
      exp_q.push_back(exp_val);
      rd_q.push_back(rd);
   endtask

   function automatic int pending();
      return op_q.size() + (in_flight ? 1 : 0);
   endfunction

   task automatic compare(input string name, input logic [31:0] exp_val,
                          input logic [31:0] act);
      if (act !== exp_val) begin
         $display("FAILED time=%0t %s expected %h actual %h", $time, name, exp_val, act);
         item_errors++;
      end
   endtask

   task automatic check_item();
      item_errors = 0;
      if (cur_op == "load" || cur_op == "alu" || cur_op == "filler") begin
         compare("reg_we", 32'd1, 32'(reg_we));
         compare("reg_rd", 32'(cur_rd), 32'(reg_rd));
         compare("reg_wdata", cur_exp, reg_wdata);
         compare("uart_we", 32'd0, 32'(uart_we));
      end else if (cur_op == "uart_store") begin
         compare("uart_we", 32'd1, 32'(uart_we));
         compare("uart_dout", cur_exp, uart_dout);
         compare("reg_we", 32'd0, 32'(reg_we));
      end else begin
         // idle, preload and memory store write nothing back
         compare("reg_we", 32'd0, 32'(reg_we));
         compare("uart_we", 32'd0, 32'(uart_we));
      end
      if (item_errors == 0) begin
         pass_count++;
         $display("pass  %s", cur_desc);
      end else begin
         fail_count++;
         $display("fail  %s", cur_desc);
      end
   endtask

   // item queued at edge N is checked in the low phase after edge N+1
   always @(negedge clk) begin
      if (in_flight) begin
         check_item();
      end
      if (op_q.size() > 0) begin
         cur_op    = op_q.pop_front();
         cur_desc  = desc_q.pop_front();
         cur_exp   = exp_q.pop_front();
         cur_rd    = rd_q.pop_front();
         in_flight = 1'b1;
      end else begin
         in_flight = 1'b0;
      end
   end

   task automatic print_totals();
      $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
   endtask

endmodule

/* dv/mem_stage_stimulus.txt */
# op addr size wdata alu_result rd expected, all hex, size 0 word 1 byte 2 half
# expected is reg_wdata for load and alu, uart_dout for uart_store, unused otherwise
preload    00000000 0 11223344 00000000 00 00000000
preload    00000004 0 a1b2c3d4 00000000 00 00000000
preload    00000008 0 deadbeef 00000000 00 00000000
preload    0000000c 0 0badf00d 00000000 00 00000000
preload    00000010 0 cafe8001 00000000 00 00000000
preload    00000ffc 0 76543210 00000000 00 00000000
load       00000004 0 00000000 00000000 01 a1b2c3d4
load       00000ffc 0 00000000 00000000 02 76543210
load       00000008 1 00000000 00000000 03 000000ef
load       00000009 1 00000000 00000000 04 000000be
load       0000000a 1 00000000 00000000 05 000000ad
load       0000000b 1 00000000 00000000 06 000000de
load       0000000c 2 00000000 00000000 07 0000f00d
load       0000000d 2 00000000 00000000 08 0000adf0
load       0000000e 2 00000000 00000000 09 00000bad
load       0000000f 2 00000000 00000000 0a 0000000b
load       00000006 0 00000000 00000000 0b 0000a1b2
store      00000011 1 ffffff5a 00000000 00 00000000
store      00000012 2 12349876 00000000 00 00000000
load       00000010 0 00000000 00000000 0c 98765a01
load       00000013 1 00000000 00000000 10 00000098
store      00000007 2 0000beef 00000000 00 00000000
load       00000004 0 00000000 00000000 0d efb2c3d4
uart_store 10000000 1 00000041 00000000 00 00000041
uart_store 10000000 0 48656c6c 00000000 00 48656c6c
load       10000000 0 00000000 00000000 0e 00000000
load       00000000 0 00000000 00000000 0f 11223344
alu        00000123 0 ffffffff 1234abcd 1f 1234abcd

/* dv/mem_stage_tb.sv */
module mem_stage_tb
   import mem_stage_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int max_lines     = 200;
   localparam int drain_limit   = 20;
   localparam int filler_cycles = 6;

   logic         clk;
   logic         reset;
   logic [31:0]  addr;
   access_size_e size;
   logic [31:0]  wdata;
   logic         store;
   logic         mem_to_reg;
   logic [31:0]  alu_result;
   logic [4:0]   rd_in;
   logic         reg_we_in;
   logic [31:0]  load_addr;
   logic [31:0]  load_data;
   logic         load_we;
   logic [31:0]  reg_wdata;
   logic         reg_we;
   logic [4:0]   reg_rd;
   logic [31:0]  uart_dout;
   logic         uart_we;

   integer seed;
   int     stim_fd;
   int     bad_lines;

   mem_stage_top #(.addr_width(12)) UUT (
      .clk        (clk),
      .reset      (reset),
      .addr       (addr),
      .size       (size),
      .wdata      (wdata),
      .store      (store),
      .mem_to_reg (mem_to_reg),
      .alu_result (alu_result),
      .rd_in      (rd_in),
      .reg_we_in  (reg_we_in),
      .load_addr  (load_addr),
      .load_data  (load_data),
      .load_we    (load_we),
      .reg_wdata  (reg_wdata),
      .reg_we     (reg_we),
      .reg_rd     (reg_rd),
      .uart_dout  (uart_dout),
      .uart_we    (uart_we)
   );

   mem_stage_checker u_checker (
      .clk       (clk),
      .reg_wdata (reg_wdata),
      .reg_we    (reg_we),
      .reg_rd    (reg_rd),
      .uart_dout (uart_dout),
      .uart_we   (uart_we)
   );

   always #2 clk = ~clk;

   function automatic bit is_known_op(input string op);
      return op == "preload" || op == "store" || op == "load" || op == "alu" ||
             op == "uart_store" || op == "filler" || op == "idle";
   endfunction

   // one request per rising edge, expected result queued alongside
   task automatic drive_request(input string op, input logic [31:0] a, input logic [1:0] sz,
                                input logic [31:0] wd, input logic [31:0] alu,
                                input logic [4:0] rd, input logic [31:0] exp_val);
      @(posedge clk);
      addr       <= a;
      size       <= access_size_e'(sz);
      wdata      <= wd;
      alu_result <= alu;
      rd_in      <= rd;
      store      <= (op == "store") || (op == "uart_store");
      mem_to_reg <= (op == "load");
      reg_we_in  <= (op == "load") || (op == "alu") || (op == "filler");
      load_we    <= (op == "preload");   // loader shares the address field
      load_addr  <= a;
      load_data  <= wd;
      u_checker.expect_item(op, $sformatf("%s %h", op, a), exp_val, rd);
   endtask

   initial begin
      string       line;
      string       op;
      logic [31:0] f_addr;
      logic [31:0] f_size;
      logic [31:0] f_wdata;
      logic [31:0] f_alu;
      logic [31:0] f_rd;
      logic [31:0] f_exp;
      int          n_fields;
      int          n_lines;
      int          drain_wait;

      clk        = 1'b0;
      reset      = 1'b1;
      addr       = uart_addr;   // UART store held through reset
      size       = size_word;
      wdata      = '0;
      store      = 1'b1;
      mem_to_reg = 1'b0;
      alu_result = '0;
      rd_in      = '0;
      reg_we_in  = 1'b1;        // write-back request held through reset
      load_addr  = '0;
      load_data  = '0;
      load_we    = 1'b0;
      seed       = 32'hb79b_9f1d;
      bad_lines  = 0;
      n_lines    = 0;

      // outputs after the last reset edge must be quiet
      @(posedge clk);
      u_checker.expect_item("idle", "outputs quiet after reset", 32'h0, 5'd0);
      @(posedge clk);
      reset     <= 1'b0;
      addr      <= '0;
      store     <= 1'b0;
      reg_we_in <= 1'b0;

      stim_fd = $fopen("dv/mem_stage_stimulus.txt", "r");
      if (stim_fd == 0) begin
         $display("could not open dv/mem_stage_stimulus.txt");
         bad_lines++;
      end else begin
         while (n_lines < max_lines) begin
            if ($fgets(line, stim_fd) == 0) break;
            n_lines++;
            if (line.len() <= 1 || line.substr(0, 0) == "#") continue;
            n_fields = $sscanf(line, "%s %h %h %h %h %h %h", op, f_addr, f_size, f_wdata,
                               f_alu, f_rd, f_exp);
            if (n_fields != 7 || !is_known_op(op)) begin
               $display("stimulus line %0d could not be read", n_lines);
               bad_lines++;
               continue;
            end
            drive_request(op, f_addr, f_size[1:0], f_wdata, f_alu, f_rd[4:0], f_exp);
         end
         if (n_lines == max_lines && !$feof(stim_fd)) begin
            $display("stimulus file has more than %0d lines", max_lines);
            bad_lines++;
         end
         $fclose(stim_fd);
      end

      // random pass-through traffic
      for (int i = 0; i < filler_cycles; i++) begin
         f_addr = $random(seed);
         f_size = $random(seed);
         f_alu  = $random(seed);
         f_rd   = $random(seed);
         drive_request("filler", f_addr, f_size[1:0], 32'h0, f_alu, f_rd[4:0], f_alu);
      end

      drain_wait = 0;
      while (u_checker.pending() != 0 && drain_wait < drain_limit) begin
         @(posedge clk);
         drain_wait++;
      end
      if (u_checker.pending() != 0) begin
         $display("timed out with %0d results never checked after %0d cycles",
                  u_checker.pending(), drain_limit);
      end

      u_checker.print_totals();
      if (u_checker.fail_count == 0 && bad_lines == 0 && u_checker.pending() == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

/* rtl/byte_lane_ram.sv */
module byte_lane_ram #(
   parameter int depth_bits = 10
) (
   input  logic                  clk,
   input  logic [depth_bits-1:0] raddr,
   input  logic [depth_bits-1:0] waddr,
   input  logic [7:0]            din,
   input  logic                  we,
   output logic [7:0]            dout
);

   logic [7:0] mem [0:(1 << depth_bits) - 1];

   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= din;
      end
   end

   // read first, same-edge write shows up next cycle
   always_ff @(posedge clk) begin
      dout <= mem[raddr];
   end

endmodule

/* rtl/data_memory.sv */
module data_memory
   import mem_stage_pkg::*;
#(
   parameter int addr_width = 12
) (
   input  logic         clk,
   input  logic         reset,
   mem_stage_if.execute acc,
   input  logic [31:0]  load_addr,
   input  logic [31:0]  load_data,
   input  logic         load_we,
   output logic [31:0]  mem_rdata,
   output logic [31:0]  uart_dout,
   output logic         uart_we
);

   logic                      store_wr;
   logic                      uart_wr;
   logic [addr_width-3:0]     bank_waddr;
   mem_word_u                 bank_wdata;
   logic [num_lanes-1:0]      bank_we;
   logic [num_lanes-1:0][7:0] bank_dout;

   assign store_wr = |acc.lane_we;
   assign uart_wr  = acc.store && acc.uart_sel;

   // program store wins, loader write is lost on a clash
   always_comb begin
      if (store_wr) begin
         bank_waddr = acc.word_addr;
         bank_wdata = acc.lane_data;
         bank_we    = acc.lane_we;
      end else if (load_we) begin
         bank_waddr      = load_addr[addr_width-1:2];
         bank_wdata.word = load_data;   // loader is always a full word
         bank_we         = '1;
      end else begin
         bank_waddr = acc.word_addr;
         bank_wdata = acc.lane_data;
         bank_we    = '0;
      end
   end

   for (genvar i = 0; i < num_lanes; i++) begin : g_bank
      byte_lane_ram #(
         .depth_bits (addr_width - 2)
      ) u_bank (
         .clk   (clk),
         .raddr (acc.word_addr),
         .waddr (bank_waddr),
         .din   (bank_wdata.lane[i]),
         .we    (bank_we[i]),
         .dout  (bank_dout[i])
      );
   end

   assign mem_rdata = bank_dout;

   always_ff @(posedge clk) begin
      if (reset) begin
         uart_we <= 1'b0;
      end else begin
         uart_we <= uart_wr;   // one-cycle strobe
      end
   end

   // holds the last word sent
   always_ff @(posedge clk) begin
      if (uart_wr) begin
         uart_dout <= acc.lane_data.word;
      end
   end

   // loader has no back-pressure, it must stay off the bus during program stores
   a_no_load_collision: assert property (
      @(posedge clk) disable iff (reset) !(store_wr && load_we)
   ) else $error("loader write to %0h lost to a store", load_addr);

   // loader words land on word boundaries only
   a_load_aligned: assert property (
      @(posedge clk) disable iff (reset) load_we |-> load_addr[1:0] == 2'b00
   ) else $error("loader write to unaligned address %0h", load_addr);

endmodule

/* rtl/load_writeback.sv */
module load_writeback
   import mem_stage_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   mem_stage_if.result acc,
   input  logic [31:0] mem_rdata,
   output logic [31:0] reg_wdata,
   output logic        reg_we,
   output logic [4:0]  reg_rd
);

   logic [1:0]   offset_q;
   access_size_e size_q;
   logic         uart_q;
   logic         mem_to_reg_q;
   logic [31:0]  alu_q;
   logic [4:0]   rd_q;
   logic         reg_we_q;
   logic [31:0]  shifted;
   logic [31:0]  load_val;

   // control lines up with the registered bank read
   always_ff @(posedge clk) begin
      if (reset) begin
         reg_we_q     <= 1'b0;
         mem_to_reg_q <= 1'b0;
         uart_q       <= 1'b0;
      end else begin
         reg_we_q     <= acc.reg_we;
         mem_to_reg_q <= acc.mem_to_reg;
         uart_q       <= acc.uart_sel;
      end
   end

   always_ff @(posedge clk) begin
      offset_q <= acc.byte_offset;
      size_q   <= acc.size;
      alu_q    <= acc.alu_result;
      rd_q     <= acc.rd;
   end

   // UART reads back as zero
   assign shifted = uart_q ? '0 : (mem_rdata >> {offset_q, 3'b000});

   // zero extension only
   always_comb begin
      case (size_q)
         size_byte: load_val = {24'h0, shifted[7:0]};
         size_half: load_val = {16'h0, shifted[15:0]};
         default:   load_val = shifted;
      endcase
   end

   assign reg_wdata = mem_to_reg_q ? load_val : alu_q;
   assign reg_we    = reg_we_q;
   assign reg_rd    = rd_q;

endmodule

/* rtl/mem_access_decode.sv */
module mem_access_decode
   import mem_stage_pkg::*;
#(
   parameter int addr_width = 12
) (
   input  logic [31:0]  addr,
   input  access_size_e size,
   input  logic [31:0]  wdata,
   input  logic         store,
   input  logic         mem_to_reg,
   input  logic [31:0]  alu_result,
   input  logic [4:0]   rd_in,
   input  logic         reg_we_in,
   mem_stage_if.decode  acc
);

   logic                 uart_hit;
   mem_word_u            masked;
   logic [num_lanes-1:0] size_we;
   mem_word_u            shifted;
   logic [num_lanes-1:0] shifted_we;

   assign uart_hit = (addr == uart_addr);

   // keep only the bytes the access size covers
   always_comb begin
      masked.word = '0;
      case (size)
         size_byte: begin
            masked.lane[0] = wdata[7:0];
            size_we        = 4'b0001;
         end
         size_half: begin
            masked.lane[0] = wdata[7:0];
            masked.lane[1] = wdata[15:8];
            size_we        = 4'b0011;
         end
         default: begin
            masked.word = wdata;
            size_we     = 4'b1111;
         end
      endcase
   end

   // move up to the byte offset, lanes past 3 fall off
   assign shifted.word = masked.word << {addr[1:0], 3'b000};
   assign shifted_we   = size_we << addr[1:0];

   assign acc.word_addr   = addr[addr_width-1:2];
   assign acc.byte_offset = addr[1:0];
   assign acc.uart_sel    = uart_hit;
   assign acc.lane_data   = shifted;
   assign acc.lane_we     = (store && !uart_hit) ? shifted_we : '0;
   assign acc.store       = store;

   // carried along for write-back
   assign acc.size       = size;
   assign acc.mem_to_reg = mem_to_reg;
   assign acc.alu_result = alu_result;
   assign acc.rd         = rd_in;
   assign acc.reg_we     = reg_we_in;

endmodule

/* rtl/mem_stage_if.sv */
interface mem_stage_if
   import mem_stage_pkg::*;
#(
   parameter int addr_width = 12
) ();

   logic [addr_width-3:0] word_addr;
   logic [num_lanes-1:0]  lane_we;
   mem_word_u             lane_data;
   logic                  uart_sel;
   logic [1:0]            byte_offset;
   access_size_e          size;
   logic                  mem_to_reg;
   logic                  reg_we;
   logic [4:0]            rd;
   logic [31:0]           alu_result;
   logic                  store;

   modport decode (
      output word_addr, lane_we, lane_data, uart_sel, byte_offset, size,
             mem_to_reg, reg_we, rd, alu_result, store
   );

   modport execute (input word_addr, lane_we, lane_data, uart_sel, store);

   modport result (input byte_offset, size, uart_sel, mem_to_reg, alu_result, rd, reg_we);

endinterface

/* rtl/mem_stage_pkg.sv */
package mem_stage_pkg;

   // UART transmit register, store only
   localparam logic [31:0] uart_addr = 32'h1000_0000;

   // byte lanes per memory word
   localparam int num_lanes = 4;

   // encoding comes from the instruction funct field
   typedef enum logic [1:0] {
      size_word = 2'd0,
      size_byte = 2'd1,
      size_half = 2'd2,
      size_rsvd = 2'd3   // treated as word
   } access_size_e;

   // one memory word, seen whole or per byte lane
   typedef union packed {
      logic [31:0]                word;
      logic [num_lanes-1:0][7:0]  lane;   // lane 0 is the lowest byte
   } mem_word_u;

endpackage

/* rtl/mem_stage_top.sv */
module mem_stage_top
   import mem_stage_pkg::*;
#(
   parameter int addr_width = 12
) (
   input  logic         clk,
   input  logic         reset,
   input  logic [31:0]  addr,
   input  access_size_e size,
   input  logic [31:0]  wdata,
   input  logic         store,
   input  logic         mem_to_reg,
   input  logic [31:0]  alu_result,
   input  logic [4:0]   rd_in,
   input  logic         reg_we_in,
   input  logic [31:0]  load_addr,
   input  logic [31:0]  load_data,
   input  logic         load_we,
   output logic [31:0]  reg_wdata,
   output logic         reg_we,
   output logic [4:0]   reg_rd,
   output logic [31:0]  uart_dout,
   output logic         uart_we
);

   logic [31:0] mem_rdata;

   mem_stage_if #(.addr_width(addr_width)) acc ();

   mem_access_decode #(.addr_width(addr_width)) u_decode (
      .addr       (addr),
      .size       (size),
      .wdata      (wdata),
      .store      (store),
      .mem_to_reg (mem_to_reg),
      .alu_result (alu_result),
      .rd_in      (rd_in),
      .reg_we_in  (reg_we_in),
      .acc        (acc.decode)
   );

   data_memory #(.addr_width(addr_width)) u_execute (
      .clk       (clk),
      .reset     (reset),
      .acc       (acc.execute),
      .load_addr (load_addr),
      .load_data (load_data),
      .load_we   (load_we),
      .mem_rdata (mem_rdata),
      .uart_dout (uart_dout),
      .uart_we   (uart_we)
   );

   load_writeback u_result (
      .clk       (clk),
      .reset     (reset),
      .acc       (acc.result),
      .mem_rdata (mem_rdata),
      .reg_wdata (reg_wdata),
      .reg_we    (reg_we),
      .reg_rd    (reg_rd)
   );

endmodule

/* sources.f */
rtl/mem_stage_pkg.sv
rtl/mem_stage_if.sv
rtl/byte_lane_ram.sv
rtl/mem_access_decode.sv
rtl/data_memory.sv
rtl/load_writeback.sv
rtl/mem_stage_top.sv
dv/mem_stage_checker.sv
dv/mem_stage_tb.sv
